/* sources.f */
source/scc_pkg.sv
source/scc_decode.sv
source/scc_wave.sv
source/scc_result.sv
source/scc_top.sv
testbench/scc_tb.sv

/* Makefile */
# Verilator build for the SCC sound subsystem testbench

VERILATOR ?= verilator
TOP       ?= scc_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG  ?= >>> PASS

SOURCES := $(wildcard source/*.sv testbench/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/scc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module scc_tb
    import scc_pkg::*;
();

    localparam int          CLK_HALF      = 4;          // 8 ns period
    localparam int          RESET_CYCLES  = 16;
    localparam int          NUM_TESTS     = 6;
    localparam int          WATCHDOG_NS   = NUM_TESTS * 300 * 16 * 8;
    localparam int          SETTLE_CYCLES = 64;         // Tone must be steady by then
    localparam int          HOLD_CYCLES   = 8;          // Sound check stays armed this long
    localparam logic [31:0] SEED          = 32'h76ca;

    // Steady tone sample and volume per channel
    localparam int SAMPLE_A = -45;                      // Chip 0 ch1 on table 0
    localparam int VOL_A    = 11;
    localparam int SAMPLE_B = 100;                      // Chip 0 ch5 on table 3
    localparam int VOL_B    = 7;
    localparam int SAMPLE_C = -80;                      // Chip 1 ch2 on table 1
    localparam int VOL_C    = 9;

    logic       clock_bus;
    logic       rst_n;
    logic       ce_3m58 = 1'b0;
    logic [1:0] ce_cnt = '0;
    addr_t      addr;
    data_t      wr_data;
    logic       wr;
    logic       rd;
    logic       cfg_wr;
    logic [1:0] cfg_num;
    logic       cfg_en;
    logic       dev_num;
    chip_sel_t  mix_enable;
    sound_t     sound;
    data_t      rd_data;
    logic       rd_valid;

    // Checker inputs driven by the tasks
    logic   chk_rd;
    logic   exp_valid;
    data_t  exp_data;
    logic   chk_sound;
    sound_t exp_sound;

    // Reference state
    data_t       ram_model [NUM_CHIPS][WAVE_BYTES];
    logic        en_model  [NUM_CHIPS];
    logic [31:0] lfsr_q;
    int          err_valid;
    int          err_data;
    int          err_sound;
    int          n_reads;
    int          n_sound;

    scc_top UUT (
        .clock_bus  (clock_bus),
        .rst_n      (rst_n),
        .ce_3m58    (ce_3m58),
        .addr       (addr),
        .wr_data    (wr_data),
        .wr         (wr),
        .rd         (rd),
        .cfg_wr     (cfg_wr),
        .cfg_num    (cfg_num),
        .cfg_en     (cfg_en),
        .dev_num    (dev_num),
        .mix_enable (mix_enable),
        .sound      (sound),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    initial begin
        clock_bus = 1'b0;
        forever #CLK_HALF clock_bus = ~clock_bus;
    end

    always @(posedge clock_bus) begin
        ce_cnt  <= ce_cnt + 2'd1;
        ce_3m58 <= (ce_cnt == 2'd3);                    // One clock in four
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_byte(output data_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b[i]   = lfsr_q[0];                         // One step per bit
        end
    endtask

    task automatic report_mismatch(input string sig, input int expv, input int actv,
                                   input bit as_hex);
        if (as_hex) begin
            $display("Fail at %0d ns: %s expected 0x%02h, got 0x%02h",
                     $time, sig, expv[7:0], actv[7:0]);
        end else begin
            $display("Fail at %0d ns: %s expected %0d, got %0d", $time, sig, expv, actv);
        end
    endtask

    task automatic cfg(input logic [1:0] num, input logic en);
        @(posedge clock_bus);
        cfg_wr  <= 1'b1;
        cfg_num <= num;
        cfg_en  <= en;
        @(posedge clock_bus);
        cfg_wr <= 1'b0;
        if (num < NUM_CHIPS) begin
            en_model[num[0]] = en;                      // Chip numbers 2 and 3 are dropped
        end
    endtask

    task automatic write_byte(input logic dev, input addr_t a, input data_t d);
        @(posedge clock_bus);
        dev_num <= dev;
        addr    <= a;
        wr_data <= d;
        wr      <= 1'b1;
        @(posedge clock_bus);
        wr <= 1'b0;
        if ((a >= SCC_BASE) && (a < SCC_LIMIT) && en_model[dev] && (a[7:0] < REG_FREQ_BASE)) begin
            ram_model[dev][a[6:0]] = d;
        end
    endtask

    task automatic read_byte(input logic dev, input addr_t a);
        logic valid;
        valid = (a >= SCC_BASE) && (a < SCC_LIMIT) && en_model[dev];
        @(posedge clock_bus);
        dev_num   <= dev;
        addr      <= a;
        rd        <= 1'b1;
        chk_rd    <= 1'b1;
        exp_valid <= valid;
        exp_data  <= (valid && (a[7:0] < REG_FREQ_BASE)) ? ram_model[dev][a[6:0]] : 8'hFF;
        @(posedge clock_bus);
        rd     <= 1'b0;
        chk_rd <= 1'b0;
        n_reads++;
    endtask

    task automatic fill_table(input logic dev, input int tbl, input data_t val);
        for (int i = 0; i < WAVE_LEN; i++) begin
            write_byte(dev, SCC_BASE + addr_t'(tbl * WAVE_LEN + i), val);
        end
    endtask

    // Channel ch counts from 0 here
    task automatic set_tone(input logic dev, input int ch, input freq_t f, input vol_t v);
        write_byte(dev, SCC_BASE + addr_t'(REG_FREQ_BASE) + addr_t'(2 * ch), f[7:0]);
        write_byte(dev, SCC_BASE + addr_t'(REG_FREQ_BASE) + addr_t'(2 * ch + 1), {4'h0, f[11:8]});
        write_byte(dev, SCC_BASE + addr_t'(REG_VOL_BASE) + addr_t'(ch), {4'h0, v});
    endtask

    task automatic set_mix(input chip_sel_t m);
        @(posedge clock_bus);
        mix_enable <= m;
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge clock_bus);
    endtask

    task automatic check_sound(input int expv);
        @(posedge clock_bus);
        chk_sound <= 1'b1;
        exp_sound <= sound_t'(expv);
        repeat (HOLD_CYCLES) @(posedge clock_bus);
        chk_sound <= 1'b0;
        n_sound++;
    endtask

    a_rd_valid : assert property (
        @(posedge clock_bus) disable iff (!rst_n)
        chk_rd |-> (rd_valid == exp_valid)
    ) else begin
        err_valid++;
        report_mismatch("rd_valid", $sampled(exp_valid), $sampled(rd_valid), 1'b0);
    end

    a_rd_data : assert property (
        @(posedge clock_bus) disable iff (!rst_n)
        chk_rd |-> (rd_data == exp_data)
    ) else begin
        err_data++;
        report_mismatch("rd_data", $sampled(exp_data), $sampled(rd_data), 1'b1);
    end

    a_sound : assert property (
        @(posedge clock_bus) disable iff (!rst_n)
        chk_sound |-> (sound == exp_sound)
    ) else begin
        err_sound++;
        report_mismatch("sound", $sampled(exp_sound), $sampled(sound), 1'b0);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        data_t b;
        int    chip0_val;
        int    chip1_val;
        int    expv;
        rst_n      = 1'b0;
        addr       = '0;
        wr_data    = '0;
        wr         = 1'b0;
        rd         = 1'b0;
        cfg_wr     = 1'b0;
        cfg_num    = '0;
        cfg_en     = 1'b0;
        dev_num    = 1'b0;
        mix_enable = 2'b11;
        chk_rd     = 1'b0;
        exp_valid  = 1'b0;
        exp_data   = 8'hFF;
        chk_sound  = 1'b0;
        exp_sound  = '0;
        en_model   = '{1'b0, 1'b0};
        lfsr_q     = SEED;
        err_valid  = 0;
        err_data   = 0;
        err_sound  = 0;
        n_reads    = 0;
        n_sound    = 0;
        repeat (RESET_CYCLES) @(posedge clock_bus);
        rst_n <= 1'b1;

        // Reset and config gating
        read_byte(1'b0, SCC_BASE);
        read_byte(1'b1, SCC_BASE + 16'h0123);
        cfg(2'd2, 1'b1);                                // No third chip so this is ignored
        read_byte(1'b0, SCC_BASE + 16'h0080);
        cfg(2'd0, 1'b1);
        read_byte(1'b0, SCC_BASE + 16'h0080);           // Valid read of a register idles high
        read_byte(1'b1, SCC_BASE + 16'h0080);           // Chip 1 still off
        cfg(2'd0, 1'b0);
        read_byte(1'b0, SCC_BASE + 16'h0080);
        check_sound(0);

        // Waveform RAM with chip 1 written through an alias of the window
        cfg(2'd0, 1'b1);
        cfg(2'd1, 1'b1);
        for (int c = 0; c < NUM_CHIPS; c++) begin
            for (int i = 0; i < WAVE_BYTES; i++) begin
                draw_byte(b);
                write_byte(c[0], (c == 0 ? SCC_BASE : 16'h9F00) + addr_t'(i), b);
            end
        end
        for (int c = 0; c < NUM_CHIPS; c++) begin
            for (int i = 0; i < WAVE_BYTES; i++) begin
                read_byte(c[0], 16'h9C00 + addr_t'(i));
            end
        end

        // Out-of-window accesses
        for (int c = 0; c < NUM_CHIPS; c++) begin
            draw_byte(b);
            write_byte(c[0], 16'h9700, b);              // Just below the window
            write_byte(c[0], 16'h977F, b);
            write_byte(c[0], SCC_LIMIT, b);             // First address past it
            write_byte(c[0], 16'hA07F, b);
            read_byte(c[0], 16'h9700);
            read_byte(c[0], 16'h977F);
            read_byte(c[0], SCC_LIMIT);
            read_byte(c[0], 16'hA07F);
            read_byte(c[0], SCC_BASE);                  // RAM must be unchanged
            read_byte(c[0], SCC_BASE + 16'h007F);
            read_byte(c[0], SCC_BASE + 16'h0080);
            read_byte(c[0], SCC_BASE + 16'h008F);
            read_byte(c[0], SCC_BASE + 16'h00FF);
        end

        // Steady tone on chip 0
        fill_table(1'b0, 0, data_t'(SAMPLE_A));
        set_tone(1'b0, 0, 12'h005, vol_t'(VOL_A));
        write_byte(1'b0, SCC_BASE + addr_t'(REG_CHAN_EN), 8'h01);
        settle();
        check_sound(SAMPLE_A * VOL_A);
        fill_table(1'b0, 3, data_t'(SAMPLE_B));         // Channel 5 plays table 3
        set_tone(1'b0, 4, 12'h003, vol_t'(VOL_B));
        write_byte(1'b0, SCC_BASE + addr_t'(REG_CHAN_EN), 8'h11);
        settle();
        chip0_val = SAMPLE_A * VOL_A + SAMPLE_B * VOL_B;
        check_sound(chip0_val);

        // Mixing of both chips
        fill_table(1'b1, 1, data_t'(SAMPLE_C));
        set_tone(1'b1, 1, 12'h002, vol_t'(VOL_C));
        write_byte(1'b1, SCC_BASE + addr_t'(REG_CHAN_EN), 8'h02);
        chip1_val = SAMPLE_C * VOL_C;
        for (int m = 3; m >= 0; m--) begin
            set_mix(chip_sel_t'(m));
            settle();
            expv = (m[0] ? chip0_val : 0) + (m[1] ? chip1_val : 0);
            check_sound(expv);
        end
        set_mix(2'b11);

        // Channel mask silences a chip with its volumes still set
        write_byte(1'b0, SCC_BASE + addr_t'(REG_CHAN_EN), 8'h00);
        settle();
        check_sound(chip1_val);
        write_byte(1'b1, SCC_BASE + addr_t'(REG_CHAN_EN), 8'h00);
        settle();
        check_sound(0);

        $display("Errors: rd_valid %0d, rd_data %0d, sound %0d (%0d reads, %0d sound checks)",
                 err_valid, err_data, err_sound, n_reads, n_sound);
        if ((err_valid + err_data + err_sound) == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : scc_tb

`default_nettype wire

/* source/scc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scc_top
    import scc_pkg::*;
(
    input  wire logic       clock_bus,
    input  wire logic       rst_n,
    input  wire logic       ce_3m58,      // SCC rate enable
    input  wire addr_t      addr,
    input  wire data_t      wr_data,
    input  wire logic       wr,
    input  wire logic       rd,
    input  wire logic       cfg_wr,       // Chip enable config strobe
    input  wire logic [1:0] cfg_num,
    input  wire logic       cfg_en,
    input  wire logic       dev_num,      // Chip targeted by the access
    input  wire chip_sel_t  mix_enable,
    output sound_t          sound,
    output data_t           rd_data,
    output logic            rd_valid
);

    chip_sel_t chip_sel;
    logic      chip_hit;
    data_t     rd_byte_0;
    data_t     rd_byte_1;
    chip_sum_t chip_sound_0;
    chip_sum_t chip_sound_1;

    scc_decode u_decode (
        .clock_bus (clock_bus),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_num   (cfg_num),
        .cfg_en    (cfg_en),
        .addr      (addr),
        .dev_num   (dev_num),
        .chip_sel  (chip_sel),
        .chip_hit  (chip_hit)
    );

    scc_wave u_chip0 (
        .clock_bus  (clock_bus),
        .rst_n      (rst_n),
        .ce_3m58    (ce_3m58),
        .req        (chip_sel[0]),
        .wr         (wr),
        .addr       (addr[7:0]),     // Offset within the chip
        .wr_data    (wr_data),
        .rd_byte    (rd_byte_0),
        .chip_sound (chip_sound_0)
    );

    scc_wave u_chip1 (
        .clock_bus  (clock_bus),
        .rst_n      (rst_n),
        .ce_3m58    (ce_3m58),
        .req        (chip_sel[1]),
        .wr         (wr),
        .addr       (addr[7:0]),
        .wr_data    (wr_data),
        .rd_byte    (rd_byte_1),
        .chip_sound (chip_sound_1)
    );

    scc_result u_result (
        .clock_bus    (clock_bus),
        .rst_n        (rst_n),
        .rd           (rd),
        .chip_hit     (chip_hit),
        .dev_num      (dev_num),
        .rd_byte_0    (rd_byte_0),
        .rd_byte_1    (rd_byte_1),
        .chip_sound_0 (chip_sound_0),
        .chip_sound_1 (chip_sound_1),
        .mix_enable   (mix_enable),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .sound        (sound)
    );

endmodule : scc_top

`default_nettype wire

/* source/scc_result.sv */
`timescale 1ns/1ps
`default_nettype none

module scc_result
    import scc_pkg::*;
(
    input  wire logic      clock_bus,
    input  wire logic      rst_n,
    input  wire logic      rd,            // Read strobe
    input  wire logic      chip_hit,      // Access selects an enabled chip
    input  wire logic      dev_num,       // Chip targeted by this access
    input  wire data_t     rd_byte_0,     // Read data of chip 0
    input  wire data_t     rd_byte_1,     // Read data of chip 1
    input  wire chip_sum_t chip_sound_0,
    input  wire chip_sum_t chip_sound_1,
    input  wire chip_sel_t mix_enable,    // Bit n adds chip n to the mix
    output data_t          rd_data,
    output logic           rd_valid,
    output sound_t         sound
);

    sound_t mix_0;                        // Chip 0 share of the mix
    sound_t mix_1;                        // Chip 1 share of the mix
    data_t  rd_sel;

    // Read path valid in the same cycle as rd
    assign rd_sel   = dev_num ? rd_byte_1 : rd_byte_0;
    assign rd_valid = rd && chip_hit;
    assign rd_data  = rd_valid ? rd_sel : RD_IDLE;   // Bus idles high

    // Sign extend each chip by one guard bit before the add
    assign mix_0 = mix_enable[0] ? {chip_sound_0[14], chip_sound_0} : '0;
    assign mix_1 = mix_enable[1] ? {chip_sound_1[14], chip_sound_1} : '0;

    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n) begin
            sound <= '0;
        end else begin
            sound <= mix_0 + mix_1;                  // Updates every clock
        end
    end

    // Data only handed back while the CPU is reading
    a_valid_rd : assert property (
        @(posedge clock_bus) disable iff (!rst_n)
        rd_valid |-> rd
    ) else $error("rd_valid high without rd");

endmodule : scc_result

`default_nettype wire

/* source/scc_wave.sv */
`timescale 1ns/1ps
`default_nettype none

module scc_wave
    import scc_pkg::*;
(
    input  wire logic  clock_bus,
    input  wire logic  rst_n,
    input  wire logic  ce_3m58,     // SCC rate enable, one cycle wide
    input  wire logic  req,         // Chip select from decode
    input  wire logic  wr,          // Write strobe
    input  wire data_t addr,        // Offset inside the chip, addr[7:0]
    input  wire data_t wr_data,     // Write data
    output data_t      rd_byte,     // Read data, combinational
    output chip_sum_t  chip_sound   // Registered channel sum
);

    localparam int RAM_AW = $clog2(WAVE_BYTES); // 7 bits for 128 bytes

    // Waveform RAM of four tables with WAVE_LEN bytes each
    data_t wave_ram [WAVE_BYTES];

    // Register file
    data_t                   freq_lo [NUM_CHANNELS];  // Low 8 bits of divider
    logic [3:0]              freq_hi [NUM_CHANNELS];  // High nibble of divider
    vol_t                    vol_q   [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] chan_mask;               // Bit n enables channel n+1

    // Channel state
    freq_t              cnt_q    [NUM_CHANNELS];      // Divider counter
    phase_t             phase_q  [NUM_CHANNELS];      // Position in table
    sample_t            sample_q [NUM_CHANNELS];      // Latched sample
    logic signed [12:0] chan_out [NUM_CHANNELS];      // Sample times volume

    logic      wr_hit;
    chip_sum_t sum_d;

    assign wr_hit = req && wr;

    // Waveform RAM write port
    always_ff @(posedge clock_bus) begin
        if (wr_hit && (addr < REG_FREQ_BASE)) begin
            wave_ram[addr[RAM_AW-1:0]] <= wr_data;
        end
    end

    // Register offsets read back as idle high
    assign rd_byte = (addr < REG_FREQ_BASE) ? wave_ram[addr[RAM_AW-1:0]] : RD_IDLE;

    // Frequency, volume and mask registers
    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                freq_lo[c] <= '0;
                freq_hi[c] <= '0;
                vol_q[c]   <= '0;
            end
            chan_mask <= '0;                           // Silent after reset
        end else if (wr_hit) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (addr == data_t'(REG_FREQ_BASE + 2 * c)) begin
                    freq_lo[c] <= wr_data;
                end
                if (addr == data_t'(REG_FREQ_BASE + 2 * c + 1)) begin
                    freq_hi[c] <= wr_data[3:0];        // Upper bits ignored
                end
                if (addr == data_t'(REG_VOL_BASE + c)) begin
                    vol_q[c] <= wr_data[3:0];
                end
            end
            if (addr == REG_CHAN_EN) begin
                chan_mask <= wr_data[NUM_CHANNELS-1:0];
            end
            // 0x90..0xFF fall through untouched
        end
    end

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        // Channel 5 plays from the table of channel 4
        localparam int TBL = (ch < WAVE_TABLES) ? ch : WAVE_TABLES - 1;

        freq_t reload;
        assign reload = {freq_hi[ch], freq_lo[ch]};

        // Divider, phase and sample latch stepped by ce
        always_ff @(posedge clock_bus or negedge rst_n) begin
            if (!rst_n) begin
                cnt_q[ch]    <= '0;
                phase_q[ch]  <= '0;
                sample_q[ch] <= '0;
            end else if (ce_3m58) begin
                sample_q[ch] <= sample_t'(wave_ram[{2'(TBL), phase_q[ch]}]);
                if (reload == '0) begin
                    cnt_q[ch] <= '0;                   // Stopped channel holds phase
                end else if (cnt_q[ch] == '0) begin
                    cnt_q[ch]   <= reload;
                    phase_q[ch] <= phase_q[ch] + 1'b1; // Wraps at end of table
                end else begin
                    cnt_q[ch] <= cnt_q[ch] - 1'b1;
                end
            end
        end

        // Masked product with the volume taken as unsigned
        assign chan_out[ch] = chan_mask[ch] ? (sample_q[ch] * $signed({1'b0, vol_q[ch]}))
                                            : 13'sd0;

        // Phase only moves on an enable cycle
        a_phase_ce : assert property (
            @(posedge clock_bus) disable iff (!rst_n)
            !$stable(phase_q[ch]) |-> $past(ce_3m58)
        ) else $error("Channel %0d phase moved without ce_3m58", ch + 1);
    end

    // Five products fit in 15 bits (max 5 * 128 * 15)
    always_comb begin
        sum_d = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            sum_d = sum_d + chip_sum_t'(chan_out[c]);  // Sign extend each product
        end
    end

    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n) begin
            chip_sound <= '0;
        end else begin
            chip_sound <= sum_d;                       // One clock behind samples
        end
    end

endmodule : scc_wave

`default_nettype wire

/* source/scc_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module scc_decode
    import scc_pkg::*;
(
    input  wire logic       clock_bus,
    input  wire logic       rst_n,
    input  wire logic       cfg_wr,     // Config strobe
    input  wire logic [1:0] cfg_num,    // Chip addressed by the config strobe
    input  wire logic       cfg_en,     // New enable value
    input  wire addr_t      addr,       // CPU address
    input  wire logic       dev_num,    // Chip targeted by this access
    output chip_sel_t       chip_sel,   // One-hot chip select
    output logic            chip_hit    // Any chip selected
);

    chip_sel_t chip_en;                 // Enable latch per chip
    logic      in_window;               // Address inside 0x9800..0x9FFF

    // Enable latches, written by the config strobe
    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n) begin
            chip_en <= '0;              // Both chips off after reset
        end else if (cfg_wr && (cfg_num < NUM_CHIPS)) begin
            chip_en[cfg_num[0]] <= cfg_en; // Numbers past the last chip are dropped
        end
    end

    assign in_window = (addr >= SCC_BASE) && (addr < SCC_LIMIT);

    // Select only the targeted chip, and only when it is switched on
    always_comb begin
        for (int i = 0; i < NUM_CHIPS; i++) begin
            chip_sel[i] = in_window && chip_en[dev_num] && (dev_num == i);
        end
    end

    assign chip_hit = |chip_sel;        // Used by the read path in the result stage

    // A single access never reaches both chips
    a_sel_onehot : assert property (
        @(posedge clock_bus) disable iff (!rst_n)
        chip_sel != 2'b11
    ) else $error("Both chip selects high at once");

    // Disabling a chip blocks its select from the next cycle on
    a_cfg_off : assert property (
        @(posedge clock_bus) disable iff (!rst_n)
        (cfg_wr && !cfg_en && (cfg_num < NUM_CHIPS)) |=> !chip_sel[$past(cfg_num[0])]
    ) else $error("Chip selected right after being disabled");

endmodule : scc_decode

`default_nettype wire

/* source/scc_pkg.sv */
`default_nettype none

package scc_pkg;

    // CPU side
    typedef logic [15:0] addr_t;            // CPU address
    typedef logic [7:0]  data_t;            // CPU data byte

    // Sound datapath
    typedef logic signed [7:0]  sample_t;   // Waveform sample, two's complement
    typedef logic [3:0]         vol_t;      // Channel volume
    typedef logic [11:0]        freq_t;     // Divider reload value
    typedef logic [4:0]         phase_t;    // Index into one 32-byte table
    typedef logic signed [14:0] chip_sum_t; // Sum of five channel products
    typedef logic signed [15:0] sound_t;    // Mixed output of both chips

    // One bit per chip
    typedef logic [1:0] chip_sel_t;

    // Memory window of the cartridge slot
    localparam addr_t SCC_BASE  = 16'h9800; // First address in window
    localparam addr_t SCC_LIMIT = 16'hA000; // First address past window

    // Chip and channel counts
    localparam int NUM_CHIPS    = 2;        // SCC chips on the cartridge
    localparam int NUM_CHANNELS = 5;        // Channels per chip
    localparam int WAVE_LEN     = 32;       // Bytes per waveform table
    localparam int WAVE_TABLES  = 4;        // Channel 5 reuses the last one
    localparam int WAVE_BYTES   = WAVE_TABLES * WAVE_LEN;

    // Register map, compared on addr[7:0]
    // 0x00..0x7F waveform RAM, four tables back to back
    // 0x80..0x89 frequency, low byte then high nibble per channel
    // 0x8A..0x8E volume per channel
    // 0x8F       channel enable mask
    localparam data_t REG_FREQ_BASE = 8'h80; // Ch1 frequency low byte
    localparam data_t REG_VOL_BASE  = 8'h8A; // Ch1 volume
    localparam data_t REG_CHAN_EN   = 8'h8F; // Channel mask, bit 0 = ch1

    // Idle value on the read bus
    localparam data_t RD_IDLE = 8'hFF;

endpackage : scc_pkg

`default_nettype wire
